// File: source/pix_pkg.sv
package pix_pkg;

    // bits per colour component
    parameter int DW = 8;

    // sum of two components needs one more bit
    parameter int LW = DW + 1;

    // index into the three-component pixel arrays
    typedef enum logic [1:0] {
        comp_y = 2'd0,   // luma, passes through
        comp_u = 2'd1,   // blue difference
        comp_v = 2'd2    // red difference
    } comp_idx_t;

endpackage

// File: source/frame_pkg.sv
package frame_pkg;

    // sensor size used when the top level is not overridden
    parameter int SENSOR_X_DEF = 720;
    parameter int SENSOR_Y_DEF = 720;

    // frame tracker states
    typedef enum logic [1:0] {
        st_idle     = 2'd0,   // outside a frame
        st_in_line  = 2'd1,   // frame and line strobes both high
        st_line_gap = 2'd2    // inside the frame, between lines
    } sync_state_t;

endpackage

// File: source/frame_sync_fsm.sv
`timescale 1ns/100ps

module frame_sync_fsm (
    input  logic clk,
    input  logic resetn,
    input  logic frame_valid_i,
    input  logic line_valid_i,
    output logic eol_o,
    output logic eof_o
);
    import frame_pkg::*;

    sync_state_t state;

    // state holds the last sampled strobes, pulses come out registered
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= st_idle;
            eol_o <= 1'b0;
            eof_o <= 1'b0;
        end else begin
            eol_o <= 1'b0;
            eof_o <= 1'b0;
            case (state)
                st_idle: begin
                    if (frame_valid_i) begin
                        state <= line_valid_i ? st_in_line : st_line_gap;
                    end
                end
                st_in_line: begin
                    if (!frame_valid_i) begin
                        // both strobes dropped together
                        state <= st_idle;
                        eol_o <= 1'b1;
                        eof_o <= 1'b1;
                    end else if (!line_valid_i) begin
                        state <= st_line_gap;
                        eol_o <= 1'b1;
                    end
                end
                st_line_gap: begin
                    if (!frame_valid_i) begin
                        state <= st_idle;
                        eof_o <= 1'b1;
                    end else if (line_valid_i) begin
                        state <= st_in_line;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // a line can only run inside a frame
    a_line_in_frame: assert property (@(posedge clk) disable iff (!resetn)
        line_valid_i |-> frame_valid_i);

endmodule

// File: source/pixel_line_counter.sv
`timescale 1ns/100ps

module pixel_line_counter #(
    parameter int SENSOR_X_SIZE = frame_pkg::SENSOR_X_DEF,
    parameter int SENSOR_Y_SIZE = frame_pkg::SENSOR_Y_DEF
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             accept_i,
    input  logic                             eol_i,
    input  logic                             eof_i,
    output logic [$clog2(SENSOR_X_SIZE)-1:0] pixel_count_o,
    output logic [$clog2(SENSOR_Y_SIZE)-1:0] line_count_o
);

    // eof wins over eol when both land in the same cycle
    always_ff @(posedge clk) begin
        if (!resetn || eof_i) begin
            pixel_count_o <= '0;
            line_count_o <= '0;
        end else if (eol_i) begin
            pixel_count_o <= '0;
            line_count_o <= line_count_o + 1'b1;   // next line of the frame
        end else if (accept_i) begin
            pixel_count_o <= pixel_count_o + 1'b1;
        end
    end

    // more pixels than the sensor width means a missed line end
    a_pixel_in_range: assert property (@(posedge clk) disable iff (!resetn)
        pixel_count_o < SENSOR_X_SIZE);

endmodule

// File: source/chroma_line_buf.sv
`timescale 1ns/100ps

module chroma_line_buf #(
    parameter int DEPTH = frame_pkg::SENSOR_X_DEF / 2
) (
    input  logic                         clk,
    input  logic                         we_i,
    input  logic [$clog2(DEPTH)-1:0]     waddr_i,
    input  logic [1:0][pix_pkg::LW-1:0]  wdata_i,
    input  logic                         re_i,
    input  logic [$clog2(DEPTH)-1:0]     raddr_i,
    output logic [1:0][pix_pkg::LW-1:0]  rdata_o
);
    import pix_pkg::*;

    // one entry per pixel pair, U sum in [0] and V sum in [1]
    logic [1:0][LW-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read data stays put until the next read enable
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

// File: source/chroma_subsampler.sv
`timescale 1ns/100ps

module chroma_subsampler #(
    parameter int SENSOR_X_SIZE = frame_pkg::SENSOR_X_DEF,
    parameter int SENSOR_Y_SIZE = frame_pkg::SENSOR_Y_DEF
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic [pix_pkg::DW-1:0]           pix_i [3],
    input  logic                             pix_valid_i,
    input  logic                             accept_i,
    input  logic                             hold_i,
    input  logic                             eof_i,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0] pixel_count_i,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0] line_count_i,
    output logic                             lb_we_o,
    output logic                             lb_re_o,
    output logic [1:0][pix_pkg::LW-1:0]      lb_wdata_o,
    input  logic [1:0][pix_pkg::LW-1:0]      lb_rdata_i,
    output logic [pix_pkg::DW-1:0]           pix_o [3],
    output logic [2:0]                       pix_valid_o,
    output logic                             eof_o,
    output logic [$clog2(SENSOR_X_SIZE)-1:0] pixel_count_o,
    output logic [$clog2(SENSOR_Y_SIZE)-1:0] line_count_o
);
    import pix_pkg::*;

    logic               odd_pix;
    logic               odd_line;
    logic               emit_uv;     // odd pixel of an odd line
    logic [DW-1:0]      u_half;      // even pixel chroma waits here
    logic [DW-1:0]      v_half;
    logic [1:0][LW-1:0] pair_sum;
    logic [LW:0]        u_blk;       // four samples plus rounding
    logic [LW:0]        v_blk;
    logic               eof_pend;    // eof seen while held

    assign odd_pix = pixel_count_i[0];
    assign odd_line = line_count_i[0];
    assign emit_uv = accept_i & odd_pix & odd_line;

    // horizontal pair sums of the current line
    assign pair_sum[0] = LW'(u_half) + LW'(pix_i[comp_u]);
    assign pair_sum[1] = LW'(v_half) + LW'(pix_i[comp_v]);

    // add the stored sums of the line above, +2 to round
    assign u_blk = (LW+1)'(lb_rdata_i[0]) + (LW+1)'(pair_sum[0]) + (LW+1)'(2);
    assign v_blk = (LW+1)'(lb_rdata_i[1]) + (LW+1)'(pair_sum[1]) + (LW+1)'(2);

    // even lines store their sums, odd lines fetch them at the even pixel
    assign lb_wdata_o = pair_sum;
    assign lb_we_o = accept_i & odd_pix & ~odd_line;
    assign lb_re_o = accept_i & ~odd_pix & odd_line;

    always_ff @(posedge clk) begin
        if (accept_i && !odd_pix) begin
            u_half <= pix_i[comp_u];
            v_half <= pix_i[comp_v];
        end
    end

    // output payload, only loaded by an accepted pixel
    always_ff @(posedge clk) begin
        if (accept_i) begin
            pix_o[comp_y] <= pix_i[comp_y];   // luma untouched
            pixel_count_o <= pixel_count_i;
            line_count_o <= line_count_i;
        end
        if (emit_uv) begin
            pix_o[comp_u] <= u_blk[LW:2];     // divide by four
            pix_o[comp_v] <= v_blk[LW:2];
        end
    end

    // valids and eof freeze while the sink holds
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pix_valid_o <= '0;
            eof_o <= 1'b0;
            eof_pend <= 1'b0;
        end else if (!hold_i) begin
            pix_valid_o[comp_y] <= accept_i;
            pix_valid_o[comp_u] <= emit_uv;
            pix_valid_o[comp_v] <= emit_uv;
            eof_o <= eof_i | eof_pend;
            eof_pend <= 1'b0;
        end else if (eof_i) begin
            eof_pend <= 1'b1;   // deliver once hold drops
        end
    end

    // accept from the top has to agree with the input handshake
    a_accept_handshake: assert property (@(posedge clk) disable iff (!resetn)
        accept_i |-> (pix_valid_i && !hold_i));

endmodule

// File: source/yuv420_top.sv
`timescale 1ns/100ps

module yuv420_top #(
    parameter int SENSOR_X_SIZE = frame_pkg::SENSOR_X_DEF,
    parameter int SENSOR_Y_SIZE = frame_pkg::SENSOR_Y_DEF
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic [pix_pkg::DW-1:0]           pix_i [3],
    input  logic                             pix_valid_i,
    output logic                             pix_hold_o,
    input  logic                             frame_valid_i,
    input  logic                             line_valid_i,
    output logic [pix_pkg::DW-1:0]           pix_o [3],
    output logic [2:0]                       pix_valid_o,   // one per component
    input  logic                             pix_hold_i,
    output logic                             eof_o,
    output logic [$clog2(SENSOR_X_SIZE)-1:0] pixel_count_o,
    output logic [$clog2(SENSOR_Y_SIZE)-1:0] line_count_o
);
    import pix_pkg::*;

    localparam int XW = $clog2(SENSOR_X_SIZE);
    localparam int YW = $clog2(SENSOR_Y_SIZE);

    logic               accept;
    logic               eol;
    logic               eof;
    logic [XW-1:0]      pixel_count;
    logic [YW-1:0]      line_count;
    logic               lb_we;
    logic               lb_re;
    logic [1:0][LW-1:0] lb_wdata;
    logic [1:0][LW-1:0] lb_rdata;

    assign pix_hold_o = pix_hold_i;   // one stage, hold passes straight back
    assign accept = line_valid_i & pix_valid_i & ~pix_hold_o;

    frame_sync_fsm u_sync (
        .clk           (clk),
        .resetn        (resetn),
        .frame_valid_i (frame_valid_i),
        .line_valid_i  (line_valid_i),
        .eol_o         (eol),
        .eof_o         (eof)
    );

    pixel_line_counter #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE)
    ) u_counter (
        .clk           (clk),
        .resetn        (resetn),
        .accept_i      (accept),
        .eol_i         (eol),
        .eof_i         (eof),
        .pixel_count_o (pixel_count),
        .line_count_o  (line_count)
    );

    // addressed by pixel pair index
    chroma_line_buf #(
        .DEPTH (SENSOR_X_SIZE / 2)
    ) u_line_buf (
        .clk     (clk),
        .we_i    (lb_we),
        .waddr_i (pixel_count[XW-1:1]),
        .wdata_i (lb_wdata),
        .re_i    (lb_re),
        .raddr_i (pixel_count[XW-1:1]),
        .rdata_o (lb_rdata)
    );

    chroma_subsampler #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE)
    ) u_subsampler (
        .clk           (clk),
        .resetn        (resetn),
        .pix_i         (pix_i),
        .pix_valid_i   (pix_valid_i),
        .accept_i      (accept),
        .hold_i        (pix_hold_o),
        .eof_i         (eof),
        .pixel_count_i (pixel_count),
        .line_count_i  (line_count),
        .lb_we_o       (lb_we),
        .lb_re_o       (lb_re),
        .lb_wdata_o    (lb_wdata),
        .lb_rdata_i    (lb_rdata),
        .pix_o         (pix_o),
        .pix_valid_o   (pix_valid_o),
        .eof_o         (eof_o),
        .pixel_count_o (pixel_count_o),
        .line_count_o  (line_count_o)
    );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic resetn
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;

    // reset released on a falling edge, away from the sampling edge
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

// File: test/yuv420_checker.sv
`timescale 1ns/100ps

module yuv420_checker #(
    parameter int XW = 3,
    parameter int YW = 2,
    parameter int CHROMA_PER_FRAME = 8
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [pix_pkg::DW-1:0] pix_o [3],
    input  logic [2:0]             pix_valid_o,
    input  logic                   pix_hold_i,
    input  logic                   pix_hold_o,
    input  logic                   eof_o,
    input  logic [XW-1:0]          pixel_count_o,
    input  logic [YW-1:0]          line_count_o
);
    import pix_pkg::*;

    // expected word: {has_uv, px, ln, y, u, v}
    logic [40:0]   exp_mem [1024];
    int            wr_ptr = 0;
    int            rd_ptr = 0;
    logic [40:0]   e;
    string         test_name = "none";
    int            err_total = 0;      // counted on the clock
    int            chroma_total = 0;
    int            eof_total = 0;
    int            end_errors = 0;     // counted at test end
    int            base_err = 0;
    int            base_chroma = 0;
    int            base_eof = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    logic [DW-1:0] last_pix [3];
    logic [2:0]    last_valid;
    logic          last_eof;
    logic [XW-1:0] last_px;
    logic [YW-1:0] last_ln;
    logic          held = 1'b0;

    task automatic start_test(input string name);
        test_name = name;
    endtask

    task automatic expect_word(input int y, input int u, input int v,
                               input int px, input int ln, input bit has_uv);
        exp_mem[wr_ptr % 1024] = {has_uv, 8'(px), 8'(ln), 8'(y), 8'(u), 8'(v)};
        wr_ptr++;
    endtask

    function automatic int outstanding();
        return wr_ptr - rd_ptr;
    endfunction

    function automatic int total_errors();
        return err_total + end_errors;
    endfunction

    task automatic check_value(input string field, input int exp_v, input int act_v);
        if (exp_v != act_v) begin
            $display("error %s %s: expected %0d actual %0d", test_name, field, exp_v, act_v);
            err_total++;
        end
    endtask

    always @(posedge clk) begin
        if (resetn) begin
            // hold goes straight back to the source
            if (pix_hold_o !== pix_hold_i) begin
                $display("error %s pix_hold_o: expected %0b actual %0b", test_name,
                         pix_hold_i, pix_hold_o);
                err_total++;
            end
            // nothing may move at an edge where hold was high
            if (held && (pix_o[0] !== last_pix[0] || pix_o[1] !== last_pix[1] ||
                         pix_o[2] !== last_pix[2] || pix_valid_o !== last_valid ||
                         eof_o !== last_eof || pixel_count_o !== last_px ||
                         line_count_o !== last_ln)) begin
                $display("test %s: outputs changed while pix_hold_i was high", test_name);
                err_total++;
            end
            if (!pix_hold_i) begin   // word taken by the sink
                if (pix_valid_o[comp_y]) begin
                    if (rd_ptr == wr_ptr) begin
                        $display("test %s: output word came out with none expected",
                                 test_name);
                        err_total++;
                    end else begin
                        e = exp_mem[rd_ptr % 1024];
                        rd_ptr++;
                        check_value("y", int'(e[23:16]), int'(pix_o[comp_y]));
                        check_value("pixel_count", int'(e[39:32]), int'(pixel_count_o));
                        check_value("line_count", int'(e[31:24]), int'(line_count_o));
                        check_value("u_valid", int'(e[40]), int'(pix_valid_o[comp_u]));
                        check_value("v_valid", int'(e[40]), int'(pix_valid_o[comp_v]));
                        if (e[40] && pix_valid_o[comp_u]) begin
                            check_value("u", int'(e[15:8]), int'(pix_o[comp_u]));
                            check_value("v", int'(e[7:0]), int'(pix_o[comp_v]));
                        end
                    end
                end else if (pix_valid_o[comp_u] || pix_valid_o[comp_v]) begin
                    $display("test %s: chroma valid without a luma word", test_name);
                    err_total++;
                end
                if (pix_valid_o[comp_u]) chroma_total++;
                if (eof_o) eof_total++;
            end
        end
        last_pix = pix_o;
        last_valid = pix_valid_o;
        last_eof = eof_o;
        last_px = pixel_count_o;
        last_ln = line_count_o;
        held = resetn & pix_hold_i;
    end

    task automatic finish_test(input int frames);
        int errs;
        int extra;
        extra = 0;
        if (rd_ptr != wr_ptr) begin
            $display("test %s: %0d expected words never came out", test_name,
                     wr_ptr - rd_ptr);
            extra++;
        end
        if (chroma_total - base_chroma != frames * CHROMA_PER_FRAME) begin
            $display("error %s chroma_words: expected %0d actual %0d", test_name,
                     frames * CHROMA_PER_FRAME, chroma_total - base_chroma);
            extra++;
        end
        if (eof_total - base_eof != frames) begin
            $display("error %s eof_pulses: expected %0d actual %0d", test_name,
                     frames, eof_total - base_eof);
            extra++;
        end
        end_errors += extra;
        errs = extra + err_total - base_err;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errs);
        end else begin
            $display("test %s: ok", test_name);
        end
        base_err = err_total;
        base_chroma = chroma_total;
        base_eof = eof_total;
        rd_ptr = wr_ptr;   // drop leftovers so the next test starts clean
    endtask

    task automatic report();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 err_total + end_errors);
    endtask

endmodule

// File: test/yuv420_tb.sv
`timescale 1ns/100ps

module yuv420_tb;
    import pix_pkg::*;

    localparam int XS = 8;
    localparam int YS = 4;
    localparam int N_TESTS = 5;
    localparam int PAT_RAMP = 0;
    localparam int PAT_CONST = 1;
    localparam int PAT_RAND = 2;

    typedef struct {
        string name;
        int    pattern;
        int    hold_pct;   // chance of hold per pixel, percent
        int    frames;
    } test_t;

    logic                     clk;
    logic                     resetn;
    logic [DW-1:0]            pix_i [3];
    logic                     pix_valid_i;
    logic                     pix_hold_o;
    logic                     frame_valid_i;
    logic                     line_valid_i;
    logic [DW-1:0]            pix_o [3];
    logic [2:0]               pix_valid_o;
    logic                     pix_hold_i;
    logic                     eof_o;
    logic [$clog2(XS)-1:0]    pixel_count_o;
    logic [$clog2(YS)-1:0]    line_count_o;
    test_t                    tests [N_TESTS];
    logic                     table_ready = 1'b0;
    logic [31:0]              rng = 32'hdeea;
    int                       frame_no = 0;
    int                       fy [YS][XS];
    int                       fu [YS][XS];
    int                       fv [YS][XS];

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(4)) u_clk (.clk(clk), .resetn(resetn));

    yuv420_top #(.SENSOR_X_SIZE(XS), .SENSOR_Y_SIZE(YS)) uut (
        .clk(clk), .resetn(resetn), .pix_i(pix_i), .pix_valid_i(pix_valid_i),
        .pix_hold_o(pix_hold_o), .frame_valid_i(frame_valid_i),
        .line_valid_i(line_valid_i), .pix_o(pix_o), .pix_valid_o(pix_valid_o),
        .pix_hold_i(pix_hold_i), .eof_o(eof_o), .pixel_count_o(pixel_count_o),
        .line_count_o(line_count_o)
    );

    yuv420_checker #(.XW($clog2(XS)), .YW($clog2(YS)), .CHROMA_PER_FRAME(XS * YS / 4)) chk (
        .clk(clk), .resetn(resetn), .pix_o(pix_o), .pix_valid_o(pix_valid_o),
        .pix_hold_i(pix_hold_i), .pix_hold_o(pix_hold_o), .eof_o(eof_o),
        .pixel_count_o(pixel_count_o), .line_count_o(line_count_o)
    );

    function automatic int next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return int'(rng & 32'h7fff_ffff);
    endfunction

    // fill one frame and queue what the DUT should give back
    task automatic build_frame(input int pattern);
        int blk_u;
        int blk_v;
        for (int ln = 0; ln < YS; ln++) begin
            for (int px = 0; px < XS; px++) begin
                case (pattern)
                    PAT_RAMP: begin
                        fy[ln][px] = (frame_no * 37 + ln * XS + px) % 256;
                        fu[ln][px] = px * 20 + ln * 3;
                        fv[ln][px] = 200 - px * 10 - ln * 5;
                    end
                    PAT_CONST: begin
                        fy[ln][px] = 128;
                        fu[ln][px] = 255;   // top of range, sum must not wrap
                        fv[ln][px] = 1;
                    end
                    default: begin
                        fy[ln][px] = next_random() % 256;
                        fu[ln][px] = next_random() % 256;
                        fv[ln][px] = next_random() % 256;
                    end
                endcase
            end
        end
        for (int ln = 0; ln < YS; ln++) begin
            for (int px = 0; px < XS; px++) begin
                blk_u = 0;
                blk_v = 0;
                if (ln % 2 == 1 && px % 2 == 1) begin
                    blk_u = (fu[ln-1][px-1] + fu[ln-1][px] + fu[ln][px-1] + fu[ln][px] + 2) / 4;
                    blk_v = (fv[ln-1][px-1] + fv[ln-1][px] + fv[ln][px-1] + fv[ln][px] + 2) / 4;
                end
                chk.expect_word(fy[ln][px], blk_u, blk_v, px, ln, ln % 2 == 1 && px % 2 == 1);
            end
        end
        frame_no++;
    endtask

    task automatic drive_frame(input int pattern, input int hold_pct);
        bit h;
        build_frame(pattern);
        frame_valid_i = 1'b1;
        @(negedge clk);
        for (int ln = 0; ln < YS; ln++) begin
            line_valid_i = 1'b1;
            for (int px = 0; px < XS; px++) begin
                pix_i[comp_y] = 8'(fy[ln][px]);
                pix_i[comp_u] = 8'(fu[ln][px]);
                pix_i[comp_v] = 8'(fv[ln][px]);
                pix_valid_i = 1'b1;
                do begin   // repeat until a cycle without hold takes the pixel
                    h = (next_random() % 100) < hold_pct;
                    pix_hold_i = h;
                    @(negedge clk);
                end while (h);
            end
            line_valid_i = 1'b0;
            pix_valid_i = 1'b0;
            pix_hold_i = 1'b0;
            repeat (3) @(negedge clk);   // line gap, lets eol clear the pixel count
        end
        frame_valid_i = 1'b0;
        repeat (5) @(negedge clk);
    endtask

    function automatic int total_frames();
        int n;
        n = 0;
        for (int t = 0; t < N_TESTS; t++) n += tests[t].frames;
        return n;
    endfunction

    // watchdog
    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = total_frames() * 2000 + 5000;
        #(limit_ns);
        $display("watchdog: run did not finish within %0d ns", limit_ns);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int n;
        pix_i[0] = '0;
        pix_i[1] = '0;
        pix_i[2] = '0;
        pix_valid_i = 1'b0;
        frame_valid_i = 1'b0;
        line_valid_i = 1'b0;
        pix_hold_i = 1'b0;
        tests[0] = '{"ramp_basic", PAT_RAMP, 0, 1};
        tests[1] = '{"constant_max", PAT_CONST, 0, 1};
        tests[2] = '{"random_rounding", PAT_RAND, 0, 1};
        tests[3] = '{"back_to_back", PAT_RAMP, 0, 2};
        tests[4] = '{"random_hold", PAT_RAND, 40, 2};
        table_ready = 1'b1;
        @(posedge resetn);
        @(negedge clk);
        for (int t = 0; t < N_TESTS; t++) begin
            chk.start_test(tests[t].name);
            for (int f = 0; f < tests[t].frames; f++) begin
                drive_frame(tests[t].pattern, tests[t].hold_pct);
            end
            n = 0;
            while (chk.outstanding() != 0 && n < 100) begin
                @(negedge clk);
                n++;
            end
            repeat (4) @(negedge clk);
            chk.finish_test(tests[t].frames);
        end
        chk.report();
        if (chk.total_errors() != 0) begin
            $display("Result: FAILED");
        end else begin
            $display("Result: PASSED");
        end
        $finish;
    end

endmodule

// File: src.f
source/pix_pkg.sv
source/frame_pkg.sv
source/frame_sync_fsm.sv
source/pixel_line_counter.sv
source/chroma_line_buf.sv
source/chroma_subsampler.sv
source/yuv420_top.sv
test/tb_clock_gen.sv
test/yuv420_checker.sv
test/yuv420_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the yuv420 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module yuv420_tb -o yuv420_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/yuv420_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
